/* common/filterPkg.sv */
`default_nettype none

package filterPkg;

    // Window geometry
    localparam int TAPS      = 24;
    localparam int LOOKAHEAD = 12;
    localparam int LOOKBACK  = 12;
    localparam int OSR       = 4;

    // Distributed arithmetic tables
    localparam int LUT_BITS = 4;
    localparam int NUM_LUTS = TAPS / LUT_BITS;
    localparam int LUT_SIZE = 2 ** LUT_BITS;

    localparam int COEFF_W    = 12;
    localparam int PART_W     = 14;
    localparam int SUM_W      = 17;
    localparam int OUT_W      = 14;
    localparam int SUM_SHIFT  = 2;
    localparam int PIPE_DEPTH = 3;

    typedef logic signed [COEFF_W-1:0] coeffT;
    typedef logic signed [PART_W-1:0]  partT;
    typedef logic signed [SUM_W-1:0]   sumT;
    typedef logic [OUT_W-1:0]          sampleT;
    typedef logic [TAPS-1:0]           windowT;

    // Signed output range, used for saturation
    localparam sumT OUT_MAX = sumT'((2 ** (OUT_W - 1)) - 1);
    localparam sumT OUT_MIN = sumT'(-(2 ** (OUT_W - 1)));

    // Symmetric low-pass, index 0 is the newest tap
    localparam coeffT COEFFS [0:TAPS-1] = '{
        12'sd1100, 12'sd1250, 12'sd1400, 12'sd1530,
        12'sd1650, 12'sd1760, 12'sd1850, 12'sd1930,
        12'sd1990, 12'sd2030, 12'sd2047, 12'sd2047,
        12'sd2047, 12'sd2047, 12'sd2030, 12'sd1990,
        12'sd1930, 12'sd1850, 12'sd1760, 12'sd1650,
        12'sd1530, 12'sd1400, 12'sd1250, 12'sd1100
    };

endpackage

`default_nettype wire

/* common/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

    localparam int PHASE_W = 2;
    localparam int FILL_W  = 5;

    typedef enum logic [1:0] {
        IDLE,
        FILL,
        PRIME,
        RUN
    } seqStateT;

    // Decimation phase within one output period
    typedef logic [PHASE_W-1:0] phaseT;

    // Bits seen since reset, saturating
    typedef logic [FILL_W-1:0] fillCountT;

endpackage

`default_nettype wire

/* rtl/decimTimer.sv */
`timescale 1ns/100ps
`default_nettype none

module decimTimer
    import ctrlPkg::*, filterPkg::*;
(
    input  wire  clkDS,
    input  wire  rst,
    input  wire  primeDone,
    output logic decimStrobe,
    output logic windowFull
);

    phaseT     phase;
    fillCountT fillCount;

    // Free-running phase, strobe on the last phase of each period
    always_ff @(posedge clkDS) begin
        if (!rst) begin
            phase <= '0;
        end else if (phase == phaseT'(OSR - 1)) begin
            phase <= '0;
        end else begin
            phase <= phase + phaseT'(1);
        end
    end

    assign decimStrobe = (phase == phaseT'(OSR - 1));

    // Counts bits entered, stops once the pipeline is primed
    always_ff @(posedge clkDS) begin
        if (!rst) begin
            fillCount <= '0;
        end else if (!primeDone && fillCount != fillCountT'(TAPS)) begin
            fillCount <= fillCount + fillCountT'(1);
        end
    end

    // The bit entering at the next edge completes the window
    assign windowFull = (fillCount >= fillCountT'(TAPS - 1));

endmodule

`default_nettype wire

/* rtl/fillSequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module fillSequencer
    import ctrlPkg::*, filterPkg::*;
(
    input  wire  clkDS,
    input  wire  rst,
    input  wire  decimStrobe,
    input  wire  windowFull,
    output logic primeDone,
    output logic valid
);

    localparam int PRIME_W = $clog2(PIPE_DEPTH);

    seqStateT           state;
    logic [PRIME_W-1:0] primeCount;

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            state      <= IDLE;
            primeCount <= '0;
            valid      <= 1'b0;
        end else begin
            unique case (state)
                IDLE: begin
                    state <= FILL;
                end
                FILL: begin
                    // First evaluation of a complete window
                    if (windowFull && decimStrobe) begin
                        state      <= PRIME;
                        primeCount <= '0;
                    end
                end
                PRIME: begin
                    if (primeCount == PRIME_W'(PIPE_DEPTH - 1)) begin
                        state <= RUN;
                        valid <= 1'b1;
                    end else begin
                        primeCount <= primeCount + PRIME_W'(1);
                    end
                end
                RUN: begin
                    state <= RUN;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign primeDone = (state == RUN);

endmodule

`default_nettype wire

/* rtl/sampleWindow.sv */
`timescale 1ns/100ps
`default_nettype none

module sampleWindow
    import filterPkg::*;
(
    input  wire    clkDS,
    input  wire    rst,
    input  wire    bitIn,
    input  wire    decimStrobe,
    output windowT window
);

    windowT shiftReg;
    windowT shiftNext;
    windowT snapshot;

    // Newest bit at index 0
    assign shiftNext = {shiftReg[TAPS-2:0], bitIn};

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            shiftReg <= '0;
            snapshot <= '0;
        end else begin
            shiftReg <= shiftNext;
            if (decimStrobe) begin
                snapshot <= shiftNext;
            end
        end
    end

    // Lookback half as is, lookahead half in reversed order
    always_comb begin
        window[TAPS-1:LOOKAHEAD] = snapshot[TAPS-1:LOOKAHEAD];
        for (int i = 0; i < LOOKAHEAD; i++) begin
            window[i] = snapshot[LOOKAHEAD-1-i];
        end
    end

endmodule

`default_nettype wire

/* daFilter/lutBank.sv */
`timescale 1ns/100ps
`default_nettype none

module lutBank
    import filterPkg::*;
(
    input  wire    clkDS,
    input  wire    rst,
    input  wire    decimStrobe,
    input  windowT window,
    output partT   partSums [NUM_LUTS],
    output logic   partValid
);

    // Tap index of a window bit, undoing the lookahead reversal
    function automatic int tapOf(int bitIdx);
        int tap;
        if (bitIdx < LOOKAHEAD) begin
            tap = LOOKAHEAD - 1 - bitIdx;
        end else begin
            tap = bitIdx;
        end
        return tap;
    endfunction

    // Entry a holds the sum of the group's coefficients selected by a
    function automatic logic [LUT_SIZE-1:0][PART_W-1:0] buildTable(int group);
        logic [LUT_SIZE-1:0][PART_W-1:0] tbl;
        partT acc;
        for (int a = 0; a < LUT_SIZE; a++) begin
            acc = '0;
            for (int b = 0; b < LUT_BITS; b++) begin
                if (a[b]) begin
                    acc = acc + partT'(COEFFS[tapOf(group * LUT_BITS + b)]);
                end
            end
            tbl[a] = acc;
        end
        return tbl;
    endfunction

    logic evalLoad;

    // Snapshot is stable one cycle after the strobe
    always_ff @(posedge clkDS) begin
        if (!rst) begin
            evalLoad  <= 1'b0;
            partValid <= 1'b0;
        end else begin
            evalLoad  <= decimStrobe;
            partValid <= evalLoad;
        end
    end

    for (genvar g = 0; g < NUM_LUTS; g++) begin : gLut
        localparam logic [LUT_SIZE-1:0][PART_W-1:0] TABLE = buildTable(g);

        always_ff @(posedge clkDS) begin
            if (evalLoad) begin
                partSums[g] <= partT'(TABLE[window[g*LUT_BITS +: LUT_BITS]]);
            end
        end
    end

endmodule

`default_nettype wire

/* daFilter/adderTree.sv */
`timescale 1ns/100ps
`default_nettype none

module adderTree
    import filterPkg::*;
(
    input  wire  clkDS,
    input  wire  rst,
    input  partT partSums [NUM_LUTS],
    input  wire  partValid,
    output sumT  sumOut,
    output logic sumValid
);

    sumT total;

    // Six operands fit one stage at this clock
    always_comb begin
        total = '0;
        for (int i = 0; i < NUM_LUTS; i++) begin
            total = total + sumT'(partSums[i]);
        end
    end

    always_ff @(posedge clkDS) begin
        if (partValid) begin
            sumOut <= total;
        end
    end

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            sumValid <= 1'b0;
        end else begin
            sumValid <= partValid;
        end
    end

endmodule

`default_nettype wire

/* rtl/outputStage.sv */
`timescale 1ns/100ps
`default_nettype none

module outputStage
    import filterPkg::*;
(
    input  wire    clkDS,
    input  wire    rst,
    input  sumT    sumOut,
    input  wire    sumValid,
    output sampleT dataOut,
    output logic   outStrobe
);

    sumT    shifted;
    sampleT clipped;
    sampleT offsetCode;

    always_comb begin
        shifted = sumOut >>> SUM_SHIFT;
        if (shifted > OUT_MAX) begin
            clipped = sampleT'(OUT_MAX);
        end else if (shifted < OUT_MIN) begin
            clipped = sampleT'(OUT_MIN);
        end else begin
            clipped = sampleT'(shifted);
        end
        // Two's complement to offset binary
        offsetCode = {~clipped[OUT_W-1], clipped[OUT_W-2:0]};
    end

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            dataOut   <= '0;
            outStrobe <= 1'b0;
        end else begin
            outStrobe <= sumValid;
            if (sumValid) begin
                dataOut <= offsetCode;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/decimFirTop.sv */
`timescale 1ns/100ps
`default_nettype none

module decimFirTop
    import filterPkg::*;
(
    input  wire    clkDS,
    input  wire    rst,
    input  wire    bitIn,
    output sampleT dataOut,
    output logic   outStrobe,
    output logic   valid
);

    logic   decimStrobe;
    logic   windowFull;
    logic   primeDone;
    windowT window;
    partT   partSums [NUM_LUTS];
    logic   partValid;
    sumT    sumOut;
    logic   sumValid;

    // Control
    decimTimer uDecimTimer (
        .clkDS      (clkDS),
        .rst        (rst),
        .primeDone  (primeDone),
        .decimStrobe(decimStrobe),
        .windowFull (windowFull)
    );

    fillSequencer uFillSequencer (
        .clkDS      (clkDS),
        .rst        (rst),
        .decimStrobe(decimStrobe),
        .windowFull (windowFull),
        .primeDone  (primeDone),
        .valid      (valid)
    );

    // Data path
    sampleWindow uSampleWindow (
        .clkDS      (clkDS),
        .rst        (rst),
        .bitIn      (bitIn),
        .decimStrobe(decimStrobe),
        .window     (window)
    );

    lutBank uLutBank (
        .clkDS      (clkDS),
        .rst        (rst),
        .decimStrobe(decimStrobe),
        .window     (window),
        .partSums   (partSums),
        .partValid  (partValid)
    );

    adderTree uAdderTree (
        .clkDS    (clkDS),
        .rst      (rst),
        .partSums (partSums),
        .partValid(partValid),
        .sumOut   (sumOut),
        .sumValid (sumValid)
    );

    outputStage uOutputStage (
        .clkDS    (clkDS),
        .rst      (rst),
        .sumOut   (sumOut),
        .sumValid (sumValid),
        .dataOut  (dataOut),
        .outStrobe(outStrobe)
    );

endmodule

`default_nettype wire

/* sim/decimFirTb_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module decimFirTbProperties
    import filterPkg::*;
(
    input wire clkDS,
    input wire rst,
    input wire outStrobe,
    input wire valid
);

    // Quiet cycles between two output strobes
    for (genvar i = 1; i < OSR; i++) begin : gGap
        strobeGap: assert property (@(posedge clkDS) disable iff (!rst)
            outStrobe |-> ##i !outStrobe)
            else $error("outStrobe high again %0d cycles after a strobe", i);
    end

    strobePeriod: assert property (@(posedge clkDS) disable iff (!rst)
        outStrobe |-> ##OSR outStrobe)
        else $error("outStrobe missing one decimation period after a strobe");

    validHeld: assert property (@(posedge clkDS) disable iff (!rst)
        valid |=> valid)
        else $error("valid fell without a reset");

    // valid comes up together with the first full-window output
    validWithStrobe: assert property (@(posedge clkDS) disable iff (!rst)
        $rose(valid) |-> outStrobe)
        else $error("valid rose without outStrobe");

endmodule

bind decimFirTop decimFirTbProperties uProperties (
    .clkDS    (clkDS),
    .rst      (rst),
    .outStrobe(outStrobe),
    .valid    (valid)
);

`default_nettype wire

/* sim/decimFirTb.sv */
`timescale 1ns/100ps
`default_nettype none

module decimFirTb
    import filterPkg::*;
();

    localparam int RESET_CYCLES   = 8;
    localparam int SEG1_BITS      = 2400;
    localparam int SEG2_BITS      = 1600;
    localparam int TIMEOUT_CYCLES = 2 * RESET_CYCLES + SEG1_BITS + SEG2_BITS + 20;
    localparam int MAX_IN_FLIGHT  = (PIPE_DEPTH + OSR - 1) / OSR;
    localparam int SEED           = 56673;
    localparam sampleT MID_CODE   = sampleT'(1 << (OUT_W - 1));

    typedef struct packed {
        logic   complete;
        logic   allZero;
        sampleT code;
    } expT;

    logic   clkDS;
    logic   rst;
    logic   bitIn;
    sampleT dataOut;
    logic   outStrobe;
    logic   valid;

    windowT hist;
    expT    expQ [$];
    int     bitsIn;
    int     evalCount;
    int     strobeCount;
    logic   seenComplete;
    int     cycles;

    decimFirTop uut (
        .clkDS    (clkDS),
        .rst      (rst),
        .bitIn    (bitIn),
        .dataOut  (dataOut),
        .outStrobe(outStrobe),
        .valid    (valid)
    );

    initial begin
        clkDS = 1'b0;
        forever #20 clkDS = ~clkDS;
    end

    always @(posedge clkDS) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the stimulus did not complete", cycles);
            abortRun();
        end
    end

    task automatic abortRun();
        $display("Regression failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic checkEq(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED time=%0t signal=%s actual=0x%0h expected=0x%0h",
                $time, name, actual, expected);
            abortRun();
        end
    endtask

    // Constant bursts inside alternating dense and sparse stretches
    function automatic logic nextBit(int idx);
        int density;
        if (idx >= 600 && idx < 700) begin
            return 1'b1;
        end else if (idx >= 1000 && idx < 1100) begin
            return 1'b0;
        end
        density = ((idx / 200) % 2 == 0) ? 70 : 30;
        return ($urandom % 100) < density;
    endfunction

    // Reference output code for one window
    function automatic sampleT filterCode(windowT taps);
        int acc;
        acc = 0;
        for (int k = 0; k < TAPS; k++) begin
            if (taps[k]) begin
                acc = acc + int'(COEFFS[k]);
            end
        end
        acc = acc >>> SUM_SHIFT;
        if (acc > (1 << (OUT_W - 1)) - 1) begin
            acc = (1 << (OUT_W - 1)) - 1;
        end else if (acc < -(1 << (OUT_W - 1))) begin
            acc = -(1 << (OUT_W - 1));
        end
        return sampleT'(acc) ^ MID_CODE;
    endfunction

    task automatic modelStep(logic b);
        expT e;
        hist = {hist[TAPS-2:0], b};
        bitsIn++;
        if (bitsIn % OSR == 0) begin
            e.complete = (bitsIn >= TAPS);
            e.allZero  = (hist == '0);
            e.code     = filterCode(hist);
            expQ.push_back(e);
            evalCount++;
        end
    endtask

    task automatic monitorOutputs();
        expT e;
        if (outStrobe) begin
            if (expQ.size() == 0) begin
                $display("outStrobe arrived with no evaluation pending");
                abortRun();
            end else begin
                e = expQ.pop_front();
                strobeCount++;
                // Entries from a partly filled window are dropped
                if (e.complete) begin
                    seenComplete = 1'b1;
                end
                if (seenComplete) begin
                    checkEq("dataOut", 32'(dataOut), 32'(e.code));
                end
                if (seenComplete && e.allZero) begin
                    checkEq("dataOut", 32'(dataOut), 32'(MID_CODE));
                end
            end
        end
        checkEq("valid", 32'(valid), 32'(seenComplete));
    endtask

    task automatic applyReset();
        rst          = 1'b0;
        bitIn        = 1'b0;
        hist         = '0;
        bitsIn       = 0;
        evalCount    = 0;
        strobeCount  = 0;
        seenComplete = 1'b0;
        expQ.delete();
        repeat (RESET_CYCLES) begin
            @(negedge clkDS);
            checkEq("valid", 32'(valid), 32'(0));
            checkEq("outStrobe", 32'(outStrobe), 32'(0));
            checkEq("dataOut", 32'(dataOut), 32'(0));
        end
    endtask

    task automatic runSegment(int numBits);
        for (int i = 0; i < numBits; i++) begin
            monitorOutputs();
            rst   = 1'b1;
            bitIn = nextBit(i);
            modelStep(bitIn);
            @(negedge clkDS);
        end
        monitorOutputs();
    endtask

    initial begin
        rst    = 1'b0;
        bitIn  = 1'b0;
        cycles = 0;
        void'($urandom(SEED));
        applyReset();
        runSegment(SEG1_BITS);
        // Second reset in the middle of the stream
        applyReset();
        runSegment(SEG2_BITS);
        // Last evaluation is still in the pipeline
        if (strobeCount == evalCount - MAX_IN_FLIGHT) begin
            $display("Regression passed");
            $finish;
        end else begin
            checkEq("outStrobe count", 32'(strobeCount), 32'(evalCount - MAX_IN_FLIGHT));
        end
    end

endmodule

`default_nettype wire

/* compile.f */
common/filterPkg.sv
common/ctrlPkg.sv
rtl/decimTimer.sv
rtl/fillSequencer.sv
rtl/sampleWindow.sv
daFilter/lutBank.sv
daFilter/adderTree.sv
rtl/outputStage.sv
rtl/decimFirTop.sv
sim/decimFirTb_properties.sv
sim/decimFirTb.sv

/* run.sh */
#!/bin/sh
# Build and run the decimating FIR regression with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module decimFirTb \
    -o decimFirSim

./obj_dir/decimFirSim
